// ==== transfer_ring.f ====
+incdir+hw
hw/xfer_pkg.sv
hw/channel_fifo_bank.sv
hw/transfer_sequencer.sv
hw/ring_credit_tx.sv
hw/transfer_top.sv
tests/transfer_tb.sv

// ==== Bender.yml ====
package:
  name: transfer_ring

sources:
  - include_dirs:
      - hw
    files:
      - hw/xfer_pkg.sv
      - hw/channel_fifo_bank.sv
      - hw/transfer_sequencer.sv
      - hw/ring_credit_tx.sv
      - hw/transfer_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/transfer_tb.sv

// ==== tests/transfer_tb.sv ====
`timescale 1ns/10ps
`include "xfer_cfg.svh"

module transfer_tb import xfer_pkg::*; ();

	localparam int CH = `XFER_CHANNELS;
	localparam int EVT = `XFER_EVENT_SAMPLES;
	localparam int EVT_WORDS = CH * EVT;
	localparam int SEG_CYCLES = 40;
	localparam int FRAME_CYCLES = 24 * SEG_CYCLES + 150 + 24;
	// Frame count x 64 words x two clock periods, plus slack for the drains
	localparam longint WATCHDOG_NS = longint'(FRAME_CYCLES) * 64 * 200 + 200000;

	logic          CLK;
	logic          RST;
	sample_frame_t frame_in;
	logic          overflow;
	ring_beat_t    ring_out;
	logic          ring_credit;

	integer seed = 38;
	int     errors = 0;
	int     checks = 0;

	// Reference model of the kept frames and the word stream
	logic [CH-1:0][`XFER_SAMPLE_W-1:0] kept_q [$];
	int         frames_kept = 0;
	int         frames_dropped = 0;
	int         rows_done = 0;
	int         rx_count = 0;
	int         returned = 0;
	int         pos = 0;
	int         events_rx = 0;
	logic [7:0] ev_num = '0;
	logic       model_ovf = 1'b0;

	// Stimulus mode
	logic frames_on;
	logic gate_frames;
	int   density;
	int   credit_rate;

	transfer_top dut_i (
		.CLK         (CLK),
		.RST         (RST),
		.frame_in    (frame_in),
		.overflow    (overflow),
		.ring_out    (ring_out),
		.ring_credit (ring_credit)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the ring link stopped delivering words after %0d events", events_rx);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h at %0t", name, exp, act, $time);
		end
	endtask

	//////////////////////////////////////////////////
	// Output monitor and reference model
	//////////////////////////////////////////////////

	task automatic watch_output();
		logic [16:0] exp_word;
		logic [16:0] act_word;
		int          d;
		check("overflow_flag", model_ovf, overflow);
		if (ring_out.valid) begin
			rx_count++;
			act_word = ring_out.word;
			check("credit_respect", 1, rx_count <= `XFER_RING_CREDITS + returned);
			if (kept_q.size() < EVT) begin
				errors++;
				$display("Word %h arrived while no complete event had been written", act_word);
			end else begin
				d = pos - 1;
				if (pos == 0)
					exp_word = {1'b1, ev_num, 8'(EVT_WORDS)};
				else
					exp_word = {1'b0, 4'(d % CH), kept_q[d / CH][d % CH]};
				check(pos == 0 ? "event_header" : "data_word", exp_word, act_word);
				// Last channel read frees one frame slot
				if (pos != 0 && d % CH == CH - 1)
					rows_done++;
				pos++;
				if (pos == EVT_WORDS + 1) begin
					pos = 0;
					ev_num++;
					events_rx++;
					repeat (EVT) void'(kept_q.pop_front());
				end
			end
		end
	endtask

	task automatic drive_inputs();
		logic take;
		take = frames_on && ($unsigned($random(seed)) % 100 < density);
		// Hold back frames that might find the FIFOs full
		if (gate_frames && (frames_kept - rows_done >= `XFER_FIFO_DEPTH))
			take = 1'b0;
		frame_in.valid = take;
		for (int i = 0; i < CH; i++)
			frame_in.samples[i] = 12'($random(seed));
		if (take) begin
			if (frames_kept - rows_done >= `XFER_FIFO_DEPTH) begin
				frames_dropped++;
				model_ovf = 1'b1;
			end else begin
				kept_q.push_back(frame_in.samples);
				frames_kept++;
			end
		end
		// Downstream returns a credit only for a word it has taken
		ring_credit = (rx_count > returned) && ($unsigned($random(seed)) % 100 < credit_rate);
		if (ring_credit)
			returned++;
	endtask

	task automatic step_cycle();
		@(negedge CLK);
		watch_output();
		drive_inputs();
	endtask

	task automatic run_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	task automatic random_segments(input int n);
		frames_on = 1'b1;
		gate_frames = 1'b1;
		repeat (n) begin
			density = $unsigned($random(seed)) % 101;
			credit_rate = 10 + $unsigned($random(seed)) % 91;
			run_cycles(SEG_CYCLES);
		end
	endtask

	// Full credit release until every complete event is out and acknowledged
	task automatic drain_link();
		int quiet;
		frames_on = 1'b0;
		credit_rate = 100;
		quiet = 0;
		while (quiet < 30) begin
			step_cycle();
			if (kept_q.size() < EVT && pos == 0 && returned == rx_count)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		RST = 1'b1;
		frame_in = '0;
		ring_credit = 1'b0;
		frames_on = 1'b0;
		gate_frames = 1'b1;
		density = 0;
		credit_rate = 0;
		repeat (2) begin
			@(negedge CLK);
			check("reset_valid", 0, ring_out.valid);
			check("reset_overflow", 0, overflow);
		end
		RST = 1'b0;

		random_segments(16);

		// Credits withheld while frames keep coming
		frames_on = 1'b1;
		gate_frames = 1'b1;
		density = 80;
		credit_rate = 0;
		run_cycles(150);
		drain_link();

		// Burst into a stalled link, at most nine data reads leave row 0
		frames_on = 1'b1;
		gate_frames = 1'b0;
		density = 100;
		credit_rate = 0;
		run_cycles(24);
		frames_on = 1'b0;
		run_cycles(20);
		check("overflow_after_burst", 1, overflow);
		drain_link();

		random_segments(8);
		drain_link();
		check("event_count", frames_kept / EVT, events_rx);

		$display("checks %0d, errors %0d, events %0d, frames kept %0d, frames dropped %0d",
			checks, errors, events_rx, frames_kept, frames_dropped);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== hw/transfer_top.sv ====
`timescale 1ns/10ps
`include "xfer_cfg.svh"

module transfer_top import xfer_pkg::*; (
	input  logic          CLK,
	input  logic          RST,
	input  sample_frame_t frame_in,
	output logic          overflow,
	output ring_beat_t    ring_out,
	input  logic          ring_credit
);

	logic [`XFER_CHANNELS-1:0] rd_ena;
	logic [`XFER_SAMPLE_W-1:0] rd_data;
	logic [4:0]                level;
	ring_beat_t                seq_beat;
	logic                      seq_credit;

	//////////////////////////////////////////////////
	// Input FIFOs, sequencer, ring transmitter
	//////////////////////////////////////////////////

	channel_fifo_bank fifo_bank_i (
		.CLK      (CLK),
		.RST      (RST),
		.frame_in (frame_in),
		.rd_ena   (rd_ena),
		.rd_data  (rd_data),
		.level    (level),
		.overflow (overflow)
	);

	transfer_sequencer sequencer_i (
		.CLK        (CLK),
		.RST        (RST),
		.level      (level),
		.rd_ena     (rd_ena),
		.rd_data    (rd_data),
		.seq_beat   (seq_beat),
		.seq_credit (seq_credit)
	);

	ring_credit_tx tx_i (
		.CLK         (CLK),
		.RST         (RST),
		.seq_beat    (seq_beat),
		.seq_credit  (seq_credit),
		.ring_out    (ring_out),
		.ring_credit (ring_credit)
	);

endmodule

// ==== hw/ring_credit_tx.sv ====
`timescale 1ns/10ps
`include "xfer_cfg.svh"

module ring_credit_tx import xfer_pkg::*; (
	input  logic       CLK,
	input  logic       RST,
	input  ring_beat_t seq_beat,
	output logic       seq_credit,
	output ring_beat_t ring_out,
	input  logic       ring_credit
);

	localparam int QW = $clog2(`XFER_TXQ_DEPTH);
	localparam int NW = $clog2(`XFER_TXQ_DEPTH + 1);
	localparam int RW = $clog2(`XFER_RING_CREDITS + 1);

	ring_word_t    q_mem [`XFER_TXQ_DEPTH];
	logic [QW-1:0] wr_ptr;
	logic [QW-1:0] rd_ptr;
	logic [NW-1:0] q_count;
	logic [RW-1:0] ring_cnt;
	logic          q_empty;
	logic          send;
	logic          bypass;
	logic          push;
	logic          pop;
	ring_word_t    head_word;
	logic          out_valid;
	ring_word_t    out_word;

	assign q_empty = (q_count == '0);
	// Empty queue passes the incoming word straight to the output register
	assign send = (!q_empty || seq_beat.valid) && (ring_cnt != '0);
	assign bypass = send && q_empty;
	assign push = seq_beat.valid && !bypass;
	assign pop = send && !q_empty;
	assign head_word = q_empty ? seq_beat.word : q_mem[rd_ptr];
	// Every departure frees one slot for the sequencer
	assign seq_credit = send;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			ring_cnt <= RW'(`XFER_RING_CREDITS);
			out_valid <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			q_count <= q_count + NW'(push) - NW'(pop);
			ring_cnt <= ring_cnt - RW'(send) + RW'(ring_credit);
			out_valid <= send;
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			q_mem[wr_ptr] <= seq_beat.word;
		if (send)
			out_word <= head_word;
	end

	assign ring_out.valid = out_valid;
	assign ring_out.word = out_word;

	// Sequencer credits bound the words in flight
	a_no_full_write: assert property (@(posedge CLK) disable iff (RST)
		push |-> (q_count != NW'(`XFER_TXQ_DEPTH)))
		else $error("write into full transmitter queue");

	a_ring_credit_max: assert property (@(posedge CLK) disable iff (RST)
		ring_cnt <= RW'(`XFER_RING_CREDITS))
		else $error("downstream returned more credits than it was given");

endmodule

// ==== hw/transfer_sequencer.sv ====
`timescale 1ns/10ps
`include "xfer_cfg.svh"

module transfer_sequencer import xfer_pkg::*; (
	input  logic                      CLK,
	input  logic                      RST,
	input  logic [4:0]                level,
	output logic [`XFER_CHANNELS-1:0] rd_ena,
	input  logic [`XFER_SAMPLE_W-1:0] rd_data,
	output ring_beat_t                seq_beat,
	input  logic                      seq_credit
);

	localparam int CW = $clog2(`XFER_CHANNELS);
	localparam int SW = $clog2(`XFER_EVENT_SAMPLES);
	localparam int KW = $clog2(`XFER_TXQ_DEPTH + 1);

	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_HEADER = 2'd1;
	localparam logic [1:0] S_READ   = 2'd2;

	logic [1:0]    state;
	logic [CW-1:0] ch_cnt;
	logic [SW-1:0] smp_cnt;
	logic [7:0]    event_num;
	logic [KW-1:0] credit;
	logic          has_credit;
	logic          drained;
	logic          event_ready;
	logic          issue_hdr;
	logic          issue_rd;
	logic          last_ch;
	logic          last_rd;
	logic [CW-1:0] rd_ch1;
	logic [CW-1:0] rd_ch2;
	logic          rd_v2;
	logic          beat_valid;
	ring_word_t    beat_word;

	assign has_credit = (credit != '0);
	// Header must not overtake data words still in the read pipeline
	assign drained = (rd_ena == '0) && !rd_v2;
	assign event_ready = drained && (level >= 5'(`XFER_EVENT_SAMPLES));
	assign issue_hdr = has_credit &&
		((state == S_IDLE && event_ready) || state == S_HEADER);
	assign issue_rd = has_credit && (state == S_READ);
	assign last_ch = (ch_cnt == CW'(`XFER_CHANNELS - 1));
	assign last_rd = last_ch && (smp_cnt == SW'(`XFER_EVENT_SAMPLES - 1));

	//////////////////////////////////////////////////
	// Event FSM and counters
	//////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= S_IDLE;
			event_num <= '0;
			ch_cnt <= '0;
			smp_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					// Event present, header waits in S_HEADER without credit
					if (event_ready)
						state <= has_credit ? S_READ : S_HEADER;
				end
				S_HEADER: begin
					if (has_credit)
						state <= S_READ;
				end
				S_READ: begin
					if (issue_rd && last_rd)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
			if (issue_hdr)
				event_num <= event_num + 8'd1;
			// Sample-major, channel-minor
			if (issue_rd) begin
				if (last_ch) begin
					ch_cnt <= '0;
					smp_cnt <= last_rd ? '0 : smp_cnt + 1'b1;
				end else begin
					ch_cnt <= ch_cnt + 1'b1;
				end
			end
		end
	end

	// Internal credits toward the transmitter queue
	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			credit <= KW'(`XFER_TXQ_DEPTH);
		else
			credit <= credit - KW'(issue_hdr | issue_rd) + KW'(seq_credit);
	end

	//////////////////////////////////////////////////
	// Read enable and data word pipeline
	//////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rd_ena <= '0;
			rd_v2 <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			rd_ena <= issue_rd ? (`XFER_CHANNELS'(1) << ch_cnt) : '0;
			rd_v2 <= |rd_ena;
			beat_valid <= issue_hdr | rd_v2;
		end
	end

	always_ff @(posedge CLK) begin
		// Delayed select follows the read by two cycles
		rd_ch1 <= ch_cnt;
		rd_ch2 <= rd_ch1;
		if (issue_hdr) begin
			beat_word.hdr.is_header <= 1'b1;
			beat_word.hdr.event_num <= event_num;
			beat_word.hdr.word_count <= 8'(`XFER_CHANNELS * `XFER_EVENT_SAMPLES);
		end else begin
			beat_word.data.is_header <= 1'b0;
			beat_word.data.channel <= rd_ch2;
			beat_word.data.sample <= rd_data;
		end
	end

	assign seq_beat.valid = beat_valid;
	assign seq_beat.word = beat_word;

	// A wrap below zero lands above the reset value
	a_credit_floor: assert property (@(posedge CLK) disable iff (RST)
		credit <= KW'(`XFER_TXQ_DEPTH))
		else $error("sequencer credit count wrapped below zero");

endmodule

// ==== hw/channel_fifo_bank.sv ====
`timescale 1ns/10ps
`include "xfer_cfg.svh"

module channel_fifo_bank import xfer_pkg::*; (
	input  logic                      CLK,
	input  logic                      RST,
	input  sample_frame_t             frame_in,
	input  logic [`XFER_CHANNELS-1:0] rd_ena,
	output logic [`XFER_SAMPLE_W-1:0] rd_data,
	output logic [4:0]                level,
	output logic                      overflow
);

	localparam int AW = $clog2(`XFER_FIFO_DEPTH);
	localparam int CW = $clog2(`XFER_CHANNELS);

	logic [`XFER_SAMPLE_W-1:0] mem [`XFER_CHANNELS][`XFER_FIFO_DEPTH];
	// Extra pointer bit separates full from empty
	logic [AW:0]               wr_ptr;
	logic [AW:0]               rd_ptr [`XFER_CHANNELS];
	logic                      wr_ok;
	logic [CW-1:0]             rd_ch;

	// Last channel is read last in every sample row,
	// so its count is the number of complete frames
	assign level = wr_ptr - rd_ptr[`XFER_CHANNELS-1];
	assign wr_ok = frame_in.valid && (level != 5'(`XFER_FIFO_DEPTH));

	// Index of the selected channel
	always_comb begin
		rd_ch = '0;
		for (int i = 0; i < `XFER_CHANNELS; i++) begin
			if (rd_ena[i])
				rd_ch = CW'(i);
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_ptr <= '0;
			overflow <= 1'b0;
			for (int i = 0; i < `XFER_CHANNELS; i++)
				rd_ptr[i] <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			// Sticky, frame lost
			if (frame_in.valid && !wr_ok)
				overflow <= 1'b1;
			for (int i = 0; i < `XFER_CHANNELS; i++) begin
				if (rd_ena[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Sample storage and output register
	//////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (wr_ok) begin
			for (int i = 0; i < `XFER_CHANNELS; i++)
				mem[i][wr_ptr[AW-1:0]] <= frame_in.samples[i];
		end
		if (rd_ena != '0)
			rd_data <= mem[rd_ch][rd_ptr[rd_ch][AW-1:0]];
	end

	a_rd_onehot: assert property (@(posedge CLK) disable iff (RST)
		$onehot0(rd_ena))
		else $error("more than one channel read in one cycle");

	// Sequencer must only start an event once every channel holds it
	a_rd_not_empty: assert property (@(posedge CLK) disable iff (RST)
		(rd_ena != '0) |-> (rd_ptr[rd_ch] != wr_ptr))
		else $error("read from empty channel %0d", rd_ch);

endmodule

// ==== hw/xfer_pkg.sv ====
`include "xfer_cfg.svh"

package xfer_pkg;

	// One input beat, all channels sampled on the same clock
	typedef struct packed {
		logic                                           valid;
		logic [`XFER_CHANNELS-1:0][`XFER_SAMPLE_W-1:0] samples;
	} sample_frame_t;

	//////////////////////////////////////////////////
	// Ring word views
	//////////////////////////////////////////////////

	typedef struct packed {
		logic       is_header;
		logic [7:0] event_num;
		logic [7:0] word_count;
	} ring_header_t;

	typedef struct packed {
		logic                      is_header;
		logic [3:0]                channel;
		logic [`XFER_SAMPLE_W-1:0] sample;
	} ring_data_t;

	// Top bit tells which view applies
	typedef union packed {
		ring_header_t hdr;
		ring_data_t   data;
	} ring_word_t;

	typedef struct packed {
		logic       valid;
		ring_word_t word;
	} ring_beat_t;

endpackage

// ==== hw/xfer_cfg.svh ====
`ifndef XFER_CFG_SVH
`define XFER_CFG_SVH

//////////////////////////////////////////////////
// Board geometry
//////////////////////////////////////////////////

`define XFER_CHANNELS      16
`define XFER_SAMPLE_W      12

// Frames held per channel FIFO
`define XFER_FIFO_DEPTH    16

// Samples per channel in one event
`define XFER_EVENT_SAMPLES 4

// Queue entries in the transmitter, equal to the sequencer's credits
`define XFER_TXQ_DEPTH     4
`define XFER_RING_CREDITS  6

`endif
